// File: verilog.f
common/isa_pkg.sv
common/rob_pkg.sv
reorder_buffer/rob_ctrl.sv
reorder_buffer/rob_entry_store.sv
reorder_buffer/rob_commit.sv
verilog/rob_top.sv
verif/rob_chk.sv
verif/rob_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f verilog.f -o rob_sim

./obj_dir/rob_sim > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation done"

// File: verif/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_tb;

  localparam int SIZE  = 8;
  localparam int CNT_W = $clog2(SIZE + 1);

  logic               gsi;
  logic               rst_n;
  logic               dispatch_valid;
  isa_pkg::dispatch_t dispatch;
  rob_pkg::rob_tag_t  alloc_tag;
  logic [CNT_W-1:0]   credit_return;
  logic               complete_valid;
  isa_pkg::complete_t complete;
  logic               retire_valid;
  rob_pkg::retire_t   retire;
  logic               redirect_valid;
  rob_pkg::redirect_t redirect;

  // --------------------
  // reference state
  // --------------------
  isa_pkg::dispatch_t disp_q[$];  // program order, oldest first
  int                 tag_q[$];
  int                 pend_q[$];  // dispatched, not completed yet
  isa_pkg::xlen_t     res_tab [SIZE];
  isa_pkg::addr_t     tgt_tab [SIZE];
  isa_pkg::addr_t     want_tgt [SIZE];

  int             credits;
  int             credit_sum;
  int             next_tag;
  int             redirect_cnt;
  int             errors;
  int             tests;
  int             failed_tests;
  int             err0;
  integer         seed;
  isa_pkg::addr_t pc;

  rob_top #(.SIZE(SIZE)) DUT (
    .gsi            (gsi),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .alloc_tag      (alloc_tag),
    .credit_return  (credit_return),
    .complete_valid (complete_valid),
    .complete       (complete),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .redirect_valid (redirect_valid),
    .redirect       (redirect)
  );

  initial gsi = 1'b0;
  always #20 gsi = ~gsi;

  // --------------------
  // reference model
  // --------------------
  function automatic rob_pkg::retire_t expect_retire(isa_pkg::dispatch_t d,
                                                     isa_pkg::xlen_t res);
    rob_pkg::retire_t r;
    r.address = d.address;
    r.result  = res;
    r.rd      = d.rd;
    r.reg_we  = d.flags.writes;
    r.mem_we  = d.flags.mem && d.flags.writes;
    return r;
  endfunction

  function automatic logic expect_redirect(isa_pkg::dispatch_t d, isa_pkg::addr_t tgt);
    return d.flags.jumps && (tgt != d.address + 32'd4);
  endfunction

  function automatic isa_pkg::instr_flags_t make_flags(logic w, logic m, logic j);
    isa_pkg::instr_flags_t f;
    f.writes = w;
    f.mem    = m;
    f.jumps  = j;
    return f;
  endfunction

  // compare process, sampled mid-cycle
  always @(negedge gsi) begin
    isa_pkg::dispatch_t d;
    rob_pkg::retire_t   exp;
    int                 t;
    logic               mis;
    if (rst_n) begin
      credits    = credits + int'(credit_return);
      credit_sum = credit_sum + int'(credit_return);
      if (credits > SIZE) begin
        $display("credit count %0d went above the buffer depth", credits);
        errors++;
      end
      if (redirect_valid) begin
        redirect_cnt++;
      end
      if (redirect_valid && !retire_valid) begin
        $display("redirect_valid seen without a retire");
        errors++;
      end
      if (retire_valid) begin
        if (disp_q.size() == 0) begin
          $display("retire seen with no instruction outstanding");
          errors++;
        end else begin
          d   = disp_q.pop_front();
          t   = tag_q.pop_front();
          exp = expect_retire(d, res_tab[t]);
          mis = expect_redirect(d, tgt_tab[t]);
          if (retire.address != exp.address) begin
            $display("[ERROR] retire.address exp %h got %h", exp.address, retire.address);
            errors++;
          end
          if (retire.result != exp.result) begin
            $display("[ERROR] retire.result exp %h got %h", exp.result, retire.result);
            errors++;
          end
          if (retire.rd != exp.rd) begin
            $display("[ERROR] retire.rd exp %h got %h", exp.rd, retire.rd);
            errors++;
          end
          if (retire.reg_we != exp.reg_we || retire.mem_we != exp.mem_we) begin
            $display("[ERROR] retire.reg_we/mem_we exp %h/%h got %h/%h",
                     exp.reg_we, exp.mem_we, retire.reg_we, retire.mem_we);
            errors++;
          end
          if (mis) begin
            if (!redirect_valid) begin
              $display("missing redirect for mispredicted jump at tag %0d", t);
              errors++;
            end else if (redirect.target != tgt_tab[t]) begin
              $display("[ERROR] redirect.target exp %h got %h", tgt_tab[t], redirect.target);
              errors++;
            end
            if (int'(credit_return) != disp_q.size()) begin
              $display("[ERROR] credit_return exp %h got %h", disp_q.size(), credit_return);
              errors++;
            end
            disp_q.delete();  // younger entries are gone
            tag_q.delete();
            next_tag = (t + 1) % SIZE;
          end else if (redirect_valid) begin
            $display("unexpected redirect for tag %0d", t);
            errors++;
          end
        end
      end
    end
  end

  // --------------------
  // stimulus helpers
  // --------------------
  task automatic tick();
    @(posedge gsi);
    #1;
  endtask

  task automatic do_reset();
    rst_n          = 1'b0;
    dispatch_valid = 1'b0;
    complete_valid = 1'b0;
    dispatch       = '0;
    complete       = '0;
    repeat (5) @(posedge gsi);
    #1;
    disp_q.delete();
    tag_q.delete();
    pend_q.delete();
    credits      = SIZE;
    credit_sum   = 0;
    next_tag     = 0;
    redirect_cnt = 0;
    rst_n        = 1'b1;
  endtask

  task automatic dispatch_one(isa_pkg::instr_flags_t fl, isa_pkg::reg_idx_t rd);
    int n;
    n = 0;
    while (credits == 0 && n < 200) begin
      tick();
      n++;
    end
    if (credits == 0) begin
      $display("dispatch stalled, no credit came back");
      errors++;
    end else begin
      dispatch.address = pc;
      dispatch.rd      = rd;
      dispatch.flags   = fl;
      dispatch_valid   = 1'b1;
      if (int'(alloc_tag) != next_tag) begin
        $display("[ERROR] alloc_tag exp %h got %h", next_tag, alloc_tag);
        errors++;
      end
      foreach (tag_q[i]) begin
        if (tag_q[i] == int'(alloc_tag)) begin
          $display("tag %0d handed out again while still in flight", tag_q[i]);
          errors++;
        end
      end
      disp_q.push_back(dispatch);
      tag_q.push_back(next_tag);
      pend_q.push_back(next_tag);
      want_tgt[next_tag] = $random(seed);
      credits--;
      next_tag = (next_tag + 1) % SIZE;
      pc       = pc + 32'd4;
      tick();
      dispatch_valid = 1'b0;
    end
  endtask

  task automatic complete_at(int idx);
    int t;
    t = pend_q[idx];
    pend_q.delete(idx);
    res_tab[t]          = $random(seed);
    tgt_tab[t]          = want_tgt[t];
    complete_valid      = 1'b1;
    complete.tag        = rob_pkg::rob_tag_t'(t);
    complete.result     = res_tab[t];
    complete.jmp_target = want_tgt[t];
    tick();
    complete_valid = 1'b0;
  endtask

  task automatic complete_random();
    int r;
    r = $random(seed);
    complete_at((r & 32'h7fff_ffff) % pend_q.size());
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((disp_q.size() != 0 || credits != SIZE) && n < 200) begin
      tick();
      n++;
    end
    if (n >= 200) begin
      $display("buffer did not drain, %0d left, %0d credits", disp_q.size(), credits);
      errors++;
    end
  endtask

  task automatic run_random(int n, logic rand_flags);
    int r;
    for (int i = 0; i < n; i++) begin
      while (credits == 0 && pend_q.size() > 0) complete_random();
      r = $random(seed);
      if (rand_flags) dispatch_one(make_flags(r[0], r[1], 1'b0), r[8:4]);
      else dispatch_one(make_flags(1'b1, 1'b0, 1'b0), r[8:4]);
      if (r[12:11] == 2'b00 && pend_q.size() > 0) complete_random();
    end
    while (pend_q.size() > 0) complete_random();
    wait_drain();
  endtask

  task automatic end_test(string name);
    tests++;
    if (errors == err0) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - err0);
    end
  endtask

  // --------------------
  // tests
  // --------------------
  initial begin
    int jtag;
    int n;
    seed         = 29644;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    pc           = 32'h0000_1000;
    do_reset();

    err0 = errors;
    for (int i = 0; i < SIZE; i++) dispatch_one(make_flags(1'b1, 1'b0, 1'b0), 5'(i));
    while (pend_q.size() > 0) complete_at(0);  // in program order
    wait_drain();
    if (credit_sum != SIZE) begin
      $display("[ERROR] credit_return total exp %h got %h", SIZE, credit_sum);
      errors++;
    end
    end_test("fill and drain");

    do_reset();
    err0 = errors;
    for (int i = 0; i < SIZE; i++) dispatch_one(make_flags(1'b1, 1'b0, 1'b0), 5'(i + 3));
    while (pend_q.size() > 0) complete_random();
    wait_drain();
    end_test("out of order completion");

    do_reset();
    err0 = errors;
    run_random(3 * SIZE, 1'b0);
    end_test("credit limit");

    do_reset();
    err0 = errors;
    dispatch_one(make_flags(1'b1, 1'b0, 1'b0), 5'd1);
    dispatch_one(make_flags(1'b0, 1'b0, 1'b1), 5'd0);
    jtag = tag_q[1];
    want_tgt[jtag] = disp_q[1].address + 32'd4;  // falls through
    dispatch_one(make_flags(1'b1, 1'b0, 1'b0), 5'd2);
    dispatch_one(make_flags(1'b1, 1'b0, 1'b0), 5'd3);
    while (pend_q.size() > 0) complete_random();
    wait_drain();
    if (redirect_cnt != 0) begin
      $display("quiet jump raised a redirect");
      errors++;
    end
    end_test("quiet jump");

    do_reset();
    err0 = errors;
    dispatch_one(make_flags(1'b1, 1'b0, 1'b0), 5'd4);
    dispatch_one(make_flags(1'b1, 1'b0, 1'b1), 5'd5);
    jtag = tag_q[1];
    want_tgt[jtag] = disp_q[1].address + 32'h40;  // taken, off the sequential path
    for (int i = 0; i < 3; i++) dispatch_one(make_flags(1'b1, 1'b0, 1'b0), 5'(i + 6));
    pend_q.delete(1);
    while (pend_q.size() > 0) complete_random();
    pend_q.push_back(jtag);
    complete_at(0);
    n = 0;
    while (redirect_cnt == 0 && n < 100) begin
      tick();
      n++;
    end
    if (redirect_cnt == 0) begin
      $display("timed out waiting for the redirect");
      errors++;
    end
    wait_drain();
    for (int i = 0; i < 3; i++) dispatch_one(make_flags(1'b1, 1'b0, 1'b0), 5'(i + 20));
    while (pend_q.size() > 0) complete_random();
    wait_drain();
    end_test("mispredicted jump");

    do_reset();
    err0 = errors;
    run_random(4 * SIZE, 1'b1);
    end_test("write flags");

    $display("tests: %0d, failed tests: %0d, errors: %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/rob_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rob_chk #(
  parameter int SIZE = 8
) (
  input  wire logic                       gsi,
  input  wire logic                       rst_n,
  input  wire logic [$clog2(SIZE+1)-1:0]  count,
  input  wire logic [$clog2(SIZE+1)-1:0]  credit_return,
  input  wire logic                       alloc_en,
  input  rob_pkg::ctrl_state_e            state
);

  // --------------------
  // pointer invariants
  // --------------------
  occupancy_bound: assert property (
    @(posedge gsi) disable iff (!rst_n) int'(count) <= SIZE
  ) else $error("occupancy %0d above buffer depth %0d", count, SIZE);

  // no alloc while flushing
  no_alloc_in_flush: assert property (
    @(posedge gsi) disable iff (!rst_n) !(alloc_en && state == rob_pkg::FLUSH)
  ) else $error("allocation during FLUSH");

  // --------------------
  // credit invariants
  // --------------------
  credit_after_reset: assert property (
    @(posedge gsi) $rose(rst_n) |-> (credit_return == '0)
  ) else $error("credit_return %0d right after reset", credit_return);

endmodule

bind rob_ctrl rob_chk #(.SIZE(SIZE)) u_chk (
  .gsi           (gsi),
  .rst_n         (rst_n),
  .count         (count_q),
  .credit_return (credit_return),
  .alloc_en      (alloc_en),
  .state         (state_q)
);

`default_nettype wire

// File: verilog/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
  parameter int SIZE = 8  // power of two, 4..64
) (
  input  wire logic                  gsi,
  input  wire logic                  rst_n,
  input  wire logic                  dispatch_valid,
  input  isa_pkg::dispatch_t         dispatch,
  output rob_pkg::rob_tag_t          alloc_tag,
  output logic [$clog2(SIZE+1)-1:0]  credit_return,
  input  wire logic                  complete_valid,
  input  isa_pkg::complete_t         complete,
  output logic                       retire_valid,
  output rob_pkg::retire_t           retire,
  output logic                       redirect_valid,
  output rob_pkg::redirect_t         redirect
);

  logic                 alloc_en;
  rob_pkg::rob_tag_t    alloc_idx;
  rob_pkg::rob_tag_t    head_idx;
  logic                 flush_all;
  logic                 pop;
  logic                 mispredict;
  rob_pkg::rob_record_t head_rec;

  // --------------------
  // control
  // --------------------
  rob_ctrl #(.SIZE(SIZE)) u_ctrl (
    .gsi            (gsi),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .alloc_en       (alloc_en),
    .alloc_idx      (alloc_idx),
    .alloc_tag      (alloc_tag),
    .head_idx       (head_idx),
    .pop            (pop),
    .mispredict     (mispredict),
    .flush_all      (flush_all),
    .credit_return  (credit_return)
  );

  // --------------------
  // datapath
  // --------------------
  rob_entry_store #(.SIZE(SIZE)) u_store (
    .gsi            (gsi),
    .rst_n          (rst_n),
    .alloc_en       (alloc_en),
    .alloc_idx      (alloc_idx),
    .dispatch       (dispatch),
    .complete_valid (complete_valid),
    .complete       (complete),
    .head_idx       (head_idx),
    .flush_all      (flush_all),
    .head_rec       (head_rec)
  );

  rob_commit u_commit (
    .gsi            (gsi),
    .rst_n          (rst_n),
    .head_rec       (head_rec),
    .pop            (pop),
    .mispredict     (mispredict),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .redirect_valid (redirect_valid),
    .redirect       (redirect)
  );

endmodule

`default_nettype wire

// File: reorder_buffer/rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit (
  input  wire logic            gsi,
  input  wire logic            rst_n,
  input  rob_pkg::rob_record_t head_rec,
  output logic                 pop,
  output logic                 mispredict,
  output logic                 retire_valid,
  output rob_pkg::retire_t     retire,
  output logic                 redirect_valid,
  output rob_pkg::redirect_t   redirect
);

  isa_pkg::addr_t seq_addr;
  logic           head_done;

  assign head_done = (head_rec.status == rob_pkg::COMPLETED);
  assign seq_addr  = head_rec.address + 32'd4;

  // --------------------
  // head decision
  // --------------------
  // no pop in the flush cycle, the younger head is about to be discarded
  assign pop        = head_done && !redirect_valid;
  assign mispredict = pop && head_rec.flags.jumps && (head_rec.jmp_target != seq_addr);

  always_ff @(posedge gsi or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid   <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      retire_valid   <= pop;
      redirect_valid <= mispredict;  // same cycle as the jump's retire
    end
  end

  // --------------------
  // retire packet
  // --------------------
  always_ff @(posedge gsi) begin
    if (pop) begin
      retire.address <= head_rec.address;
      retire.result  <= head_rec.result;
      retire.rd      <= head_rec.rd;
      retire.reg_we  <= head_rec.flags.writes;
      retire.mem_we  <= head_rec.flags.mem & head_rec.flags.writes;
    end
    if (mispredict) begin
      redirect.target <= head_rec.jmp_target;
    end
  end

endmodule

`default_nettype wire

// File: reorder_buffer/rob_entry_store.sv
`timescale 1ns/1ps
`default_nettype none

module rob_entry_store #(
  parameter int SIZE = 8
) (
  input  wire logic                 gsi,
  input  wire logic                 rst_n,
  input  wire logic                 alloc_en,
  input  rob_pkg::rob_tag_t         alloc_idx,
  input  isa_pkg::dispatch_t        dispatch,
  input  wire logic                 complete_valid,
  input  isa_pkg::complete_t        complete,
  input  rob_pkg::rob_tag_t         head_idx,
  input  wire logic                 flush_all,
  output rob_pkg::rob_record_t      head_rec
);

  localparam int IDX_W = $clog2(SIZE);

  rob_pkg::entry_status_e status_q [SIZE];
  isa_pkg::addr_t         addr_q   [SIZE];
  isa_pkg::xlen_t         result_q [SIZE];
  isa_pkg::addr_t         target_q [SIZE];
  isa_pkg::reg_idx_t      rd_q     [SIZE];
  isa_pkg::instr_flags_t  flags_q  [SIZE];

  logic [IDX_W-1:0] a_idx;
  logic [IDX_W-1:0] c_idx;
  logic [IDX_W-1:0] h_idx;
  logic             head_done;

  assign a_idx = alloc_idx[IDX_W-1:0];
  assign c_idx = complete.tag[IDX_W-1:0];
  assign h_idx = head_idx[IDX_W-1:0];

  // commit pops any completed head, so the slot is freed here too
  assign head_done = (status_q[h_idx] == rob_pkg::COMPLETED);

  // --------------------
  // entry status
  // --------------------
  always_ff @(posedge gsi or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SIZE; i++) begin
        status_q[i] <= rob_pkg::EMPTY;
      end
    end else if (flush_all) begin
      for (int i = 0; i < SIZE; i++) begin
        status_q[i] <= rob_pkg::EMPTY;
      end
    end else begin
      if (head_done) status_q[h_idx] <= rob_pkg::EMPTY;
      if (complete_valid) status_q[c_idx] <= rob_pkg::COMPLETED;
      if (alloc_en) status_q[a_idx] <= rob_pkg::WAITING;
    end
  end

  // payload
  always_ff @(posedge gsi) begin
    if (alloc_en) begin
      addr_q[a_idx]  <= dispatch.address;
      rd_q[a_idx]    <= dispatch.rd;
      flags_q[a_idx] <= dispatch.flags;
    end
    if (complete_valid) begin
      result_q[c_idx] <= complete.result;
      if (flags_q[c_idx].jumps) target_q[c_idx] <= complete.jmp_target;
    end
  end

  always_comb begin
    head_rec.address    = addr_q[h_idx];
    head_rec.result     = result_q[h_idx];
    head_rec.jmp_target = target_q[h_idx];
    head_rec.rd         = rd_q[h_idx];
    head_rec.flags      = flags_q[h_idx];
    head_rec.status     = status_q[h_idx];
  end

endmodule

`default_nettype wire

// File: reorder_buffer/rob_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rob_ctrl #(
  parameter int SIZE = 8
) (
  input  wire logic                        gsi,
  input  wire logic                        rst_n,
  input  wire logic                        dispatch_valid,
  output logic                             alloc_en,
  output rob_pkg::rob_tag_t                alloc_idx,
  output rob_pkg::rob_tag_t                alloc_tag,
  output rob_pkg::rob_tag_t                head_idx,
  input  wire logic                        pop,
  input  wire logic                        mispredict,
  output logic                             flush_all,
  output logic [$clog2(SIZE+1)-1:0]        credit_return
);

  localparam int IDX_W = $clog2(SIZE);
  localparam int CNT_W = $clog2(SIZE + 1);

  logic [IDX_W-1:0]     head_q;
  logic [IDX_W-1:0]     tail_q;
  logic [CNT_W-1:0]     count_q;   // occupancy
  logic [CNT_W-1:0]     credit_q;
  rob_pkg::ctrl_state_e state_q;

  // --------------------
  // allocation
  // --------------------
  // a dispatch during the mispredict cycle or FLUSH is dropped
  assign alloc_en  = dispatch_valid && (state_q == rob_pkg::RUN) && !mispredict;
  assign alloc_idx = rob_pkg::rob_tag_t'(tail_q);
  assign alloc_tag = rob_pkg::rob_tag_t'(tail_q);  // same cycle as dispatch
  assign head_idx  = rob_pkg::rob_tag_t'(head_q);

  assign flush_all     = (state_q == rob_pkg::FLUSH);
  assign credit_return = credit_q;

  // --------------------
  // pointers and FSM
  // --------------------
  always_ff @(posedge gsi or negedge rst_n) begin
    if (!rst_n) begin
      head_q   <= '0;
      tail_q   <= '0;
      count_q  <= '0;
      credit_q <= '0;
      state_q  <= rob_pkg::RUN;
    end else begin
      case (state_q)
        rob_pkg::RUN: begin
          if (mispredict) begin
            // jump at head retires, everything behind it goes
            head_q   <= head_q + IDX_W'(1);
            count_q  <= count_q - CNT_W'(1);
            credit_q <= count_q - CNT_W'(1) + CNT_W'(dispatch_valid);
            state_q  <= rob_pkg::FLUSH;
          end else begin
            if (alloc_en) begin
              tail_q <= tail_q + IDX_W'(1);
            end
            if (pop) begin
              head_q <= head_q + IDX_W'(1);
            end
            count_q  <= count_q + CNT_W'(alloc_en) - CNT_W'(pop);
            credit_q <= CNT_W'(pop);  // one credit per retire
          end
        end
        rob_pkg::FLUSH: begin
          tail_q   <= head_q;  // store empties itself this edge
          count_q  <= '0;
          // slot of the retired jump, plus an ignored dispatch
          credit_q <= CNT_W'(1) + CNT_W'(dispatch_valid);
          state_q  <= rob_pkg::RUN;
        end
        default: begin
          state_q <= rob_pkg::RUN;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: common/rob_pkg.sv
`default_nettype none

package rob_pkg;

  // slot index, only log2(SIZE) low bits are used
  typedef isa_pkg::tag_t rob_tag_t;

  // --------------------
  // entry bookkeeping
  // --------------------
  typedef enum logic [1:0] {
    EMPTY,
    WAITING,
    COMPLETED
  } entry_status_e;

  typedef struct packed {
    isa_pkg::addr_t        address;
    isa_pkg::xlen_t        result;
    isa_pkg::addr_t        jmp_target;
    isa_pkg::reg_idx_t     rd;
    isa_pkg::instr_flags_t flags;
    entry_status_e         status;
  } rob_record_t;

  // --------------------
  // commit side
  // --------------------
  typedef struct packed {
    isa_pkg::addr_t    address;
    isa_pkg::xlen_t    result;
    isa_pkg::reg_idx_t rd;
    logic              reg_we;
    logic              mem_we;  // store flag only, no write done here
  } retire_t;

  typedef struct packed {
    isa_pkg::addr_t target;
  } redirect_t;

  // controller
  typedef enum logic {
    RUN,
    FLUSH
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: common/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // --------------------
  // basic widths
  // --------------------
  typedef logic [31:0] xlen_t;     // data word
  typedef logic [31:0] addr_t;     // instruction address
  typedef logic [4:0]  reg_idx_t;  // architectural register
  typedef logic [7:0]  tag_t;      // execution tag, low bits index the buffer

  // --------------------
  // instruction flags
  // --------------------
  typedef struct packed {
    logic writes;  // writes rd
    logic mem;     // store to memory
    logic jumps;   // control transfer
  } instr_flags_t;

  // --------------------
  // dispatcher to buffer
  // --------------------
  typedef struct packed {
    addr_t        address;
    reg_idx_t     rd;
    instr_flags_t flags;
  } dispatch_t;

  // execution unit result, arrives out of order
  typedef struct packed {
    tag_t  tag;
    xlen_t result;
    addr_t jmp_target;  // only meaningful for jumps
  } complete_t;

endpackage

`default_nettype wire
